//--- hw/lcd_video_pkg.sv
package lcd_video_pkg;

  // raster and display widths
  typedef logic [9:0]  coord_t;
  typedef logic [23:0] rgb_t;
  typedef logic [7:0]  vram_addr_t;
  typedef logic [3:0]  nibble_t;
  typedef logic [4:0]  lcd_col_t;
  typedef logic [3:0]  lcd_row_t;
  // screen pixels counted inside one dot
  typedef logic [4:0]  dot_px_t;

  // visible area and blanking
  localparam coord_t ACTIVE_W      = 10'd720;
  localparam coord_t ACTIVE_H      = 10'd720;
  localparam coord_t H_BLANK_LEN   = 10'd19;
  localparam coord_t V_BLANK_LEN   = 10'd19;
  localparam coord_t H_SYNC_OFFSET = 10'd5;
  localparam coord_t V_SYNC_OFFSET = 10'd5;

  localparam coord_t H_TOTAL  = ACTIVE_W + H_BLANK_LEN;
  localparam coord_t V_TOTAL  = ACTIVE_H + V_BLANK_LEN;
  localparam coord_t H_SYNC_X = ACTIVE_W + H_SYNC_OFFSET;
  localparam coord_t V_SYNC_Y = ACTIVE_H + V_SYNC_OFFSET;

  // emulated lcd geometry
  localparam int PIXEL_SIZE = 22;
  localparam int LCD_COLS   = 32;
  localparam int LCD_ROWS   = 16;

  // dot window is centred on the screen
  localparam coord_t LCD_X_OFFSET = coord_t'((ACTIVE_W - LCD_COLS * PIXEL_SIZE) / 2);
  localparam coord_t LCD_Y_OFFSET = coord_t'((ACTIVE_H - LCD_ROWS * PIXEL_SIZE) / 2);
  localparam coord_t LCD_X_END    = coord_t'(LCD_X_OFFSET + LCD_COLS * PIXEL_SIZE);
  localparam coord_t LCD_Y_END    = coord_t'(LCD_Y_OFFSET + LCD_ROWS * PIXEL_SIZE);

  // display ram layout, rows 8 to 15 live in the second bank
  localparam int         VRAM_DEPTH = 160;
  localparam vram_addr_t BANK1_BASE = 8'd80;

  // palette
  localparam rgb_t BORDER_RGB  = 24'hE1E6A3;
  localparam rgb_t DOT_OFF_RGB = 24'hA7C9D9;
  localparam rgb_t DOT_ON_RGB  = 24'h0A0A0A;

endpackage

//--- hw/video_timing.sv
`timescale 1ns/1ps

module video_timing (
  input  logic                 clk,
  input  logic                 reset,
  output lcd_video_pkg::coord_t x,
  output lcd_video_pkg::coord_t y,
  output logic                 de,
  output logic                 hsync,
  output logic                 vsync
);

  logic x_last;
  logic y_last;

  assign x_last = (x == lcd_video_pkg::coord_t'(lcd_video_pkg::H_TOTAL - 10'd1));
  assign y_last = (y == lcd_video_pkg::coord_t'(lcd_video_pkg::V_TOTAL - 10'd1));

  // horizontal counter, free running
  always_ff @(posedge clk) begin
    if (reset) begin
      x <= '0;
    end else if (x_last) begin
      x <= '0;
    end else begin
      x <= x + 10'd1;
    end
  end

  // vertical counter advances once per line
  always_ff @(posedge clk) begin
    if (reset) begin
      y <= '0;
    end else if (x_last) begin
      if (y_last) begin
        y <= '0;
      end else begin
        y <= y + 10'd1;
      end
    end
  end

  assign de = (x < lcd_video_pkg::ACTIVE_W) && (y < lcd_video_pkg::ACTIVE_H);

  // one clock pulses inside blanking
  assign hsync = (x == lcd_video_pkg::H_SYNC_X);

  // vsync lands on the hsync of the sync line
  assign vsync = hsync && (y == lcd_video_pkg::V_SYNC_Y);

endmodule

//--- hw/lcd_scan_mapper.sv
`timescale 1ns/1ps

module lcd_scan_mapper (
  input  logic                      clk,
  input  logic                      reset,
  input  lcd_video_pkg::coord_t     x_in,
  input  lcd_video_pkg::coord_t     y_in,
  input  logic                      de_in,
  input  logic                      hsync_in,
  input  logic                      vsync_in,
  output lcd_video_pkg::vram_addr_t vram_addr,
  output logic [1:0]                bit_sel,
  output logic                      in_lcd,
  output lcd_video_pkg::coord_t     x_out,
  output lcd_video_pkg::coord_t     y_out,
  output logic                      de_out,
  output logic                      hsync_out,
  output logic                      vsync_out
);

  logic                      in_win_x;
  logic                      in_win_y;
  logic                      px_wrap;
  logic                      py_wrap;
  lcd_video_pkg::dot_px_t    px_cnt;
  lcd_video_pkg::dot_px_t    py_cnt;
  lcd_video_pkg::lcd_col_t   dot_col;
  lcd_video_pkg::lcd_row_t   dot_row;
  logic [5:0]                ctrl_col;
  lcd_video_pkg::vram_addr_t addr_next;

  // controller column order, four groups of eight
  // 0-7 straight, 8-15 skip col 8, 16-23 run 36 down, 24-31 run 27 down
  function automatic logic [5:0] permute_col(lcd_video_pkg::lcd_col_t col);
    logic [5:0] c;
    c = {1'b0, col};
    case (col[4:3])
      2'd0:    permute_col = c;
      2'd1:    permute_col = c + 6'd1;
      2'd2:    permute_col = 6'd52 - c;
      default: permute_col = 6'd51 - c;
    endcase
  endfunction

  assign in_win_x = (x_in >= lcd_video_pkg::LCD_X_OFFSET) && (x_in < lcd_video_pkg::LCD_X_END);
  assign in_win_y = (y_in >= lcd_video_pkg::LCD_Y_OFFSET) && (y_in < lcd_video_pkg::LCD_Y_END);
  assign px_wrap  = (px_cnt == lcd_video_pkg::dot_px_t'(lcd_video_pkg::PIXEL_SIZE - 1));
  assign py_wrap  = (py_cnt == lcd_video_pkg::dot_px_t'(lcd_video_pkg::PIXEL_SIZE - 1));

  // column tracking, cleared whenever x is outside the window
  always_ff @(posedge clk) begin
    if (reset || !in_win_x) begin
      px_cnt  <= '0;
      dot_col <= '0;
    end else if (px_wrap) begin
      px_cnt  <= '0;
      dot_col <= dot_col + 5'd1;
    end else begin
      px_cnt <= px_cnt + 5'd1;
    end
  end

  // row tracking steps on the last clock of each line
  always_ff @(posedge clk) begin
    if (reset) begin
      py_cnt  <= '0;
      dot_row <= '0;
    end else if (x_in == lcd_video_pkg::coord_t'(lcd_video_pkg::H_TOTAL - 10'd1)) begin
      if (!in_win_y) begin
        py_cnt  <= '0;
        dot_row <= '0;
      end else if (py_wrap) begin
        py_cnt  <= '0;
        dot_row <= dot_row + 4'd1;
      end else begin
        py_cnt <= py_cnt + 5'd1;
      end
    end
  end

  // two nibbles per column, row bit 2 picks the upper one
  assign ctrl_col  = permute_col(dot_col);
  assign addr_next = {1'b0, ctrl_col, dot_row[2]} +
                     (dot_row[3] ? lcd_video_pkg::BANK1_BASE : 8'd0);

  always_ff @(posedge clk) begin
    if (reset) begin
      vram_addr <= '0;
      bit_sel   <= '0;
      in_lcd    <= 1'b0;
      x_out     <= '0;
      y_out     <= '0;
      de_out    <= 1'b0;
      hsync_out <= 1'b0;
      vsync_out <= 1'b0;
    end else begin
      vram_addr <= addr_next;
      bit_sel   <= dot_row[1:0];
      in_lcd    <= in_win_x && in_win_y;
      x_out     <= x_in;
      y_out     <= y_in;
      de_out    <= de_in;
      hsync_out <= hsync_in;
      vsync_out <= vsync_in;
    end
  end

endmodule

//--- hw/lcd_display_ram.sv
`timescale 1ns/1ps

module lcd_display_ram (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      wr_en,
  input  lcd_video_pkg::vram_addr_t wr_addr,
  input  lcd_video_pkg::nibble_t    wr_data,
  input  lcd_video_pkg::vram_addr_t rd_addr,
  input  logic [1:0]                bit_sel_in,
  input  logic                      in_lcd_in,
  input  lcd_video_pkg::coord_t     x_in,
  input  lcd_video_pkg::coord_t     y_in,
  input  logic                      de_in,
  input  logic                      hsync_in,
  input  logic                      vsync_in,
  output lcd_video_pkg::nibble_t    rd_data,
  output logic [1:0]                bit_sel_out,
  output logic                      in_lcd_out,
  output lcd_video_pkg::coord_t     x_out,
  output lcd_video_pkg::coord_t     y_out,
  output logic                      de_out,
  output logic                      hsync_out,
  output logic                      vsync_out
);

  lcd_video_pkg::nibble_t mem [lcd_video_pkg::VRAM_DEPTH];

  // cpu side, addresses past the end are dropped
  always_ff @(posedge clk) begin
    if (wr_en && (wr_addr < lcd_video_pkg::VRAM_DEPTH)) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // scan side, old data wins on a same-cycle collision
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      bit_sel_out <= '0;
      in_lcd_out  <= 1'b0;
      x_out       <= '0;
      y_out       <= '0;
      de_out      <= 1'b0;
      hsync_out   <= 1'b0;
      vsync_out   <= 1'b0;
    end else begin
      bit_sel_out <= bit_sel_in;
      in_lcd_out  <= in_lcd_in;
      x_out       <= x_in;
      y_out       <= y_in;
      de_out      <= de_in;
      hsync_out   <= hsync_in;
      vsync_out   <= vsync_in;
    end
  end

endmodule

//--- hw/lcd_pixel_shader.sv
`timescale 1ns/1ps

module lcd_pixel_shader (
  input  logic                   clk,
  input  logic                   reset,
  input  lcd_video_pkg::nibble_t rd_data,
  input  logic [1:0]             bit_sel,
  input  logic                   in_lcd,
  input  lcd_video_pkg::coord_t  x_in,
  input  lcd_video_pkg::coord_t  y_in,
  input  logic                   de_in,
  input  logic                   hsync_in,
  input  logic                   vsync_in,
  output lcd_video_pkg::rgb_t    rgb,
  output lcd_video_pkg::coord_t  pix_x,
  output lcd_video_pkg::coord_t  pix_y,
  output logic                   de,
  output logic                   hsync,
  output logic                   vsync
);

  logic                dot_on;
  lcd_video_pkg::rgb_t rgb_next;

  // each nibble bit is one dot of a four-row strip
  assign dot_on = rd_data[bit_sel];

  always_comb begin
    if (!de_in) begin
      rgb_next = '0;
    end else if (!in_lcd) begin
      rgb_next = lcd_video_pkg::BORDER_RGB;
    end else if (dot_on) begin
      rgb_next = lcd_video_pkg::DOT_ON_RGB;
    end else begin
      rgb_next = lcd_video_pkg::DOT_OFF_RGB;
    end
  end

  // final stage, colour and raster leave together
  always_ff @(posedge clk) begin
    if (reset) begin
      rgb   <= '0;
      pix_x <= '0;
      pix_y <= '0;
      de    <= 1'b0;
      hsync <= 1'b0;
      vsync <= 1'b0;
    end else begin
      rgb   <= rgb_next;
      pix_x <= x_in;
      pix_y <= y_in;
      de    <= de_in;
      hsync <= hsync_in;
      vsync <= vsync_in;
    end
  end

endmodule

//--- hw/lcd_video_top.sv
`timescale 1ns/1ps

module lcd_video_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      wr_en,
  input  lcd_video_pkg::vram_addr_t wr_addr,
  input  lcd_video_pkg::nibble_t    wr_data,
  output lcd_video_pkg::coord_t     pix_x,
  output lcd_video_pkg::coord_t     pix_y,
  output logic                      de,
  output logic                      hsync,
  output logic                      vsync,
  output lcd_video_pkg::rgb_t       rgb
);

  // stage 0 raster
  lcd_video_pkg::coord_t     x_0;
  lcd_video_pkg::coord_t     y_0;
  logic                      de_0;
  logic                      hsync_0;
  logic                      vsync_0;

  // stage 1 mapper outputs
  lcd_video_pkg::vram_addr_t addr_1;
  logic [1:0]                bit_sel_1;
  logic                      in_lcd_1;
  lcd_video_pkg::coord_t     x_1;
  lcd_video_pkg::coord_t     y_1;
  logic                      de_1;
  logic                      hsync_1;
  logic                      vsync_1;

  // stage 2 ram outputs
  lcd_video_pkg::nibble_t    data_2;
  logic [1:0]                bit_sel_2;
  logic                      in_lcd_2;
  lcd_video_pkg::coord_t     x_2;
  lcd_video_pkg::coord_t     y_2;
  logic                      de_2;
  logic                      hsync_2;
  logic                      vsync_2;

  video_timing video_timing_inst (
    .clk   (clk),
    .reset (reset),
    .x     (x_0),
    .y     (y_0),
    .de    (de_0),
    .hsync (hsync_0),
    .vsync (vsync_0)
  );

  lcd_scan_mapper lcd_scan_mapper_inst (
    .clk       (clk),
    .reset     (reset),
    .x_in      (x_0),
    .y_in      (y_0),
    .de_in     (de_0),
    .hsync_in  (hsync_0),
    .vsync_in  (vsync_0),
    .vram_addr (addr_1),
    .bit_sel   (bit_sel_1),
    .in_lcd    (in_lcd_1),
    .x_out     (x_1),
    .y_out     (y_1),
    .de_out    (de_1),
    .hsync_out (hsync_1),
    .vsync_out (vsync_1)
  );

  lcd_display_ram lcd_display_ram_inst (
    .clk         (clk),
    .reset       (reset),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .rd_addr     (addr_1),
    .bit_sel_in  (bit_sel_1),
    .in_lcd_in   (in_lcd_1),
    .x_in        (x_1),
    .y_in        (y_1),
    .de_in       (de_1),
    .hsync_in    (hsync_1),
    .vsync_in    (vsync_1),
    .rd_data     (data_2),
    .bit_sel_out (bit_sel_2),
    .in_lcd_out  (in_lcd_2),
    .x_out       (x_2),
    .y_out       (y_2),
    .de_out      (de_2),
    .hsync_out   (hsync_2),
    .vsync_out   (vsync_2)
  );

  lcd_pixel_shader lcd_pixel_shader_inst (
    .clk      (clk),
    .reset    (reset),
    .rd_data  (data_2),
    .bit_sel  (bit_sel_2),
    .in_lcd   (in_lcd_2),
    .x_in     (x_2),
    .y_in     (y_2),
    .de_in    (de_2),
    .hsync_in (hsync_2),
    .vsync_in (vsync_2),
    .rgb      (rgb),
    .pix_x    (pix_x),
    .pix_y    (pix_y),
    .de       (de),
    .hsync    (hsync),
    .vsync    (vsync)
  );

endmodule

//--- tests/lcd_video_checker.sv
`timescale 1ns/1ps

module lcd_video_checker (
  input logic                clk,
  input logic                reset,
  input logic                de,
  input logic                hsync,
  input logic                vsync,
  input lcd_video_pkg::rgb_t rgb
);

  // sync pulses last exactly one clock
  hsync_single: assert property (@(posedge clk) disable iff (reset) hsync |=> !hsync)
    else $error("hsync stayed high for more than one clock");

  vsync_single: assert property (@(posedge clk) disable iff (reset) vsync |=> !vsync)
    else $error("vsync stayed high for more than one clock");

  // vsync rides on the hsync of its line
  vsync_with_hsync: assert property (@(posedge clk) disable iff (reset) vsync |-> hsync)
    else $error("vsync pulsed without hsync");

  // blanking is black
  rgb_black_blank: assert property (@(posedge clk) disable iff (reset) !de |-> rgb == '0)
    else $error("rgb is not zero while de is low");

  // sync sits inside blanking
  hsync_in_blank: assert property (@(posedge clk) disable iff (reset) hsync |-> !de)
    else $error("de is high during hsync");

endmodule

bind lcd_video_top lcd_video_checker lcd_video_checker_inst (
  .clk   (clk),
  .reset (reset),
  .de    (de),
  .hsync (hsync),
  .vsync (vsync),
  .rgb   (rgb)
);

//--- tests/lcd_video_tb.sv
`timescale 1ns/1ps

module lcd_video_tb;

  logic                      clk = 1'b0;
  logic                      reset;
  logic                      wr_en;
  lcd_video_pkg::vram_addr_t wr_addr;
  lcd_video_pkg::nibble_t    wr_data;
  lcd_video_pkg::coord_t     pix_x;
  lcd_video_pkg::coord_t     pix_y;
  logic                      de;
  logic                      hsync;
  logic                      vsync;
  lcd_video_pkg::rgb_t       rgb;

  // raster period and sync positions from the blanking rules
  int h_period  = int'(lcd_video_pkg::ACTIVE_W) + int'(lcd_video_pkg::H_BLANK_LEN);
  int v_period  = int'(lcd_video_pkg::ACTIVE_H) + int'(lcd_video_pkg::V_BLANK_LEN);
  int h_sync_at = int'(lcd_video_pkg::ACTIVE_W) + int'(lcd_video_pkg::H_SYNC_OFFSET);
  int v_sync_at = int'(lcd_video_pkg::ACTIVE_H) + int'(lcd_video_pkg::V_SYNC_OFFSET);

  // software copy of the display ram
  lcd_video_pkg::nibble_t shadow [lcd_video_pkg::VRAM_DEPTH];

  // raster model: stage 0 counters and a three stage delay line
  int                    mx;
  int                    my;
  lcd_video_pkg::coord_t exp_x [3];
  lcd_video_pkg::coord_t exp_y [3];
  logic                  exp_de [3];
  logic                  exp_hs [3];
  logic                  exp_vs [3];
  logic                  armed = 1'b0;

  lcd_video_top lcd_video_top_inst (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .pix_x   (pix_x),
    .pix_y   (pix_y),
    .de      (de),
    .hsync   (hsync),
    .vsync   (vsync),
    .rgb     (rgb)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  // controller column order, written out group by group
  function automatic int ctrl_column(int col);
    if (col < 8) return col;
    else if (col < 16) return col + 1;
    else if (col < 24) return 36 - (col - 16);
    else return 27 - (col - 24);
  endfunction

  function automatic lcd_video_pkg::rgb_t expected_rgb(lcd_video_pkg::coord_t x,
                                                       lcd_video_pkg::coord_t y,
                                                       logic de_v);
    int                     xi;
    int                     yi;
    int                     row;
    int                     addr;
    logic [1:0]             bit_pos;
    lcd_video_pkg::nibble_t nib;
    xi = int'(x) - int'(lcd_video_pkg::LCD_X_OFFSET);
    yi = int'(y) - int'(lcd_video_pkg::LCD_Y_OFFSET);
    if (!de_v) return '0;
    if (xi < 0 || yi < 0 || xi >= lcd_video_pkg::LCD_COLS * lcd_video_pkg::PIXEL_SIZE ||
        yi >= lcd_video_pkg::LCD_ROWS * lcd_video_pkg::PIXEL_SIZE) begin
      return lcd_video_pkg::BORDER_RGB;
    end
    row = yi / lcd_video_pkg::PIXEL_SIZE;
    // upper nibble of a column holds rows 4 to 7 of its bank
    addr = 2 * ctrl_column(xi / lcd_video_pkg::PIXEL_SIZE) + (row / 4) % 2;
    if (row >= 8) addr = addr + int'(lcd_video_pkg::BANK1_BASE);
    nib = shadow[lcd_video_pkg::vram_addr_t'(addr)];
    bit_pos = 2'(row % 4);
    return nib[bit_pos] ? lcd_video_pkg::DOT_ON_RGB : lcd_video_pkg::DOT_OFF_RGB;
  endfunction

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "stopping after the first failure");
  endtask

  task automatic check_rgb(string name, lcd_video_pkg::rgb_t got, lcd_video_pkg::rgb_t want);
    if (got !== want) begin
      $display("CHECK FAILED %s: got %h expected %h at %0t", name, got, want, $time);
      abort_run();
    end
  endtask

  task automatic check_coord(string name, lcd_video_pkg::coord_t got,
                             lcd_video_pkg::coord_t want);
    if (got !== want) begin
      $display("CHECK FAILED %s: got %h expected %h at %0t", name, got, want, $time);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic got, logic want);
    if (got !== want) begin
      $display("CHECK FAILED %s: got %h expected %h at %0t", name, got, want, $time);
      abort_run();
    end
  endtask

  // outputs are read before the edge updates them
  always @(posedge clk) begin : compare_outputs
    lcd_video_pkg::rgb_t want;
    if (armed) begin
      want = expected_rgb(exp_x[2], exp_y[2], exp_de[2]);
      check_coord("pix_x", pix_x, exp_x[2]);
      check_coord("pix_y", pix_y, exp_y[2]);
      check_bit("de", de, exp_de[2]);
      check_bit("hsync", hsync, exp_hs[2]);
      check_bit("vsync", vsync, exp_vs[2]);
      check_rgb("rgb", rgb, want);
    end
    if (reset) begin
      mx = 0;
      my = 0;
      exp_x  = '{default: '0};
      exp_y  = '{default: '0};
      exp_de = '{default: 1'b0};
      exp_hs = '{default: 1'b0};
      exp_vs = '{default: 1'b0};
      armed  = 1'b1;
    end else begin
      exp_x[2]  = exp_x[1];
      exp_x[1]  = exp_x[0];
      exp_y[2]  = exp_y[1];
      exp_y[1]  = exp_y[0];
      exp_de[2] = exp_de[1];
      exp_de[1] = exp_de[0];
      exp_hs[2] = exp_hs[1];
      exp_hs[1] = exp_hs[0];
      exp_vs[2] = exp_vs[1];
      exp_vs[1] = exp_vs[0];
      exp_x[0]  = lcd_video_pkg::coord_t'(mx);
      exp_y[0]  = lcd_video_pkg::coord_t'(my);
      exp_de[0] = (mx < int'(lcd_video_pkg::ACTIVE_W)) && (my < int'(lcd_video_pkg::ACTIVE_H));
      exp_hs[0] = (mx == h_sync_at);
      exp_vs[0] = (mx == h_sync_at) && (my == v_sync_at);
      if (mx == h_period - 1) begin
        mx = 0;
        my = (my == v_period - 1) ? 0 : my + 1;
      end else begin
        mx = mx + 1;
      end
    end
  end

  task automatic write_nibble(lcd_video_pkg::vram_addr_t addr, lcd_video_pkg::nibble_t data);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    shadow[addr] = data;
    @(negedge clk);
  endtask

  task automatic wait_vsync();
    @(negedge clk);
    while (!vsync) @(negedge clk);
  endtask

  initial begin
    lcd_video_pkg::vram_addr_t addr;
    reset   = 1'b1;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    void'($urandom(32'h812de683));
    for (int i = 0; i < lcd_video_pkg::VRAM_DEPTH; i++) begin
      shadow[lcd_video_pkg::vram_addr_t'(i)] = lcd_video_pkg::nibble_t'($urandom());
    end
    repeat (3) @(negedge clk);
    reset = 1'b0;
    // fill the ram long before the first window line
    for (int i = 0; i < lcd_video_pkg::VRAM_DEPTH; i++) begin
      addr = lcd_video_pkg::vram_addr_t'(i);
      write_nibble(addr, shadow[addr]);
    end
    wr_en = 1'b0;
    // vertical blanking of frame one, flip some nibbles
    wait_vsync();
    repeat (20) begin
      addr = lcd_video_pkg::vram_addr_t'($urandom_range(lcd_video_pkg::VRAM_DEPTH - 1, 0));
      write_nibble(addr, ~shadow[addr]);
    end
    wr_en = 1'b0;
    // frame two visible area is complete at its vsync
    wait_vsync();
    $display("All checks passed");
    $finish;
  end

  // three frames plus some margin
  initial begin
    longint limit_ns;
    limit_ns = longint'(h_period) * longint'(v_period) * 12 + 40000;
    #(limit_ns);
    $display("timeout: the run did not finish within three frames");
    abort_run();
  end

endmodule

//--- files.f
hw/lcd_video_pkg.sv
hw/video_timing.sv
hw/lcd_scan_mapper.sv
hw/lcd_display_ram.sv
hw/lcd_pixel_shader.sv
hw/lcd_video_top.sv
tests/lcd_video_checker.sv
tests/lcd_video_tb.sv

//--- Makefile
# Verilator build of the LCD video testbench

VERILATOR ?= verilator
TOP       ?= lcd_video_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM)

clean:
	rm -rf $(OBJ_DIR)
